// ==== design/ps2_pkg.sv ====
// ----------------------------------------------------------
// Shared types, port offsets, command codes and bit positions
// for the PS/2 keyboard and mouse controller
// ----------------------------------------------------------

package ps2_pkg;

  // ----------------------------------------------------------
  // Types
  // ----------------------------------------------------------
  typedef logic [7:0] byte_t;     // Data byte, register value or command
  typedef logic [2:0] reg_addr_t; // {wb_adr_i[2:1], wb_sel_i[1]}

  // Frame receiver states
  typedef enum logic [1:0] {
    RX_IDLE,   // Waiting for a start bit
    RX_SHIFT,  // Collecting data, parity and stop
    RX_HOLD    // Byte presented, handshake in progress
  } rx_state_t;

  // ----------------------------------------------------------
  // Port offsets inside the 8-bit port space
  // ----------------------------------------------------------
  localparam reg_addr_t ADDR_DATA = 3'd0; // 0x60 data
  localparam reg_addr_t ADDR_SPK  = 3'd1; // 0x61 chassis speaker
  localparam reg_addr_t ADDR_CMD  = 3'd4; // 0x64 command / status

  // Controller commands written to 0x64
  localparam byte_t CMD_RD_CNTL   = 8'h20; // Next data read returns control byte
  localparam byte_t CMD_WR_CNTL   = 8'h60; // Next data write loads control byte
  localparam byte_t CMD_SELF_TEST = 8'hAA; // Controller self test
  localparam byte_t CMD_MSE_TEST  = 8'hA9; // Mouse interface test

  // Canned replies
  localparam byte_t SELF_TEST_OK = 8'h55;
  localparam byte_t MSE_TEST_OK  = 8'h00;

  localparam byte_t CNTL_RESET = 8'h47; // Both interrupts on, SYS flag, translate

  // Control byte bits
  localparam int CNTL_KBD_INT = 0; // IRQ1 enable
  localparam int CNTL_MSE_INT = 1; // IRQ12 enable

  // Status byte bits
  localparam int ST_IBF  = 0; // Something waiting at 0x60
  localparam int ST_SYS  = 2; // System flag, always set
  localparam int ST_INH  = 4; // Keyboard not inhibited
  localparam int ST_MOBF = 5; // Mouse byte waiting
  localparam int ST_PERR = 7; // Sticky parity error

endpackage

// ==== design/ps2_rx_if.sv ====
// ----------------------------------------------------------
// One received PS/2 byte handed to the output buffer
// through a four-phase req/ack handshake
// ----------------------------------------------------------
`timescale 1ns/1ps

interface ps2_rx_if;

  logic              req;   // Byte valid, held until ack
  logic              ack;   // Byte captured by the buffer
  ps2_pkg::byte_t    data;  // Stable while req is high
  logic              perr;  // Even parity seen on this byte

  // Receiver side
  modport tx (output req, output data, output perr, input ack);

  // Output buffer side
  modport rx (input req, input data, input perr, output ack);

endinterface

// ==== design/kbc_obuf_if.sv ====
// ----------------------------------------------------------
// Output buffer flags and pop strobe shared with the
// command and bus block
// ----------------------------------------------------------
`timescale 1ns/1ps

interface kbc_obuf_if;

  logic              kbd_full;   // Keyboard byte waiting
  logic              mse_full;   // Mouse byte waiting
  ps2_pkg::byte_t    obuf_data;  // Mouse byte first, else keyboard byte
  logic              perr_flag;  // Sticky parity error
  logic              pop;        // One-cycle pulse, shown byte consumed

  // Buffer side
  modport obuf (output kbd_full, output mse_full, output obuf_data,
                output perr_flag, input pop);

  // Command block side
  modport cmd (input kbd_full, input mse_full, input obuf_data,
               input perr_flag, output pop);

endinterface

// ==== design/ps2_rx.sv ====
// ----------------------------------------------------------
// PS/2 frame receiver, one per device; presents each byte
// on a req/ack handshake with a parity error flag
// ----------------------------------------------------------
`timescale 1ns/1ps

module ps2_rx #(
  parameter int FILTER_LEN = 4  // Equal samples before filtered clock moves
) (
  input  logic wb_clk_i,
  input  logic wb_rst_i,
  input  logic ps2_clk_i,   // Raw PS/2 clock from the device
  input  logic ps2_dat_i,   // Raw PS/2 data from the device
  ps2_rx_if.tx rx
);

  localparam int CNT_W = $clog2(FILTER_LEN + 1);

  logic                clk_s1_q, clk_s2_q;  // Clock synchronizer
  logic                dat_s1_q, dat_s2_q;  // Data synchronizer
  logic                clk_flt_q;           // Filtered PS/2 clock
  logic [CNT_W-1:0]    flt_cnt_q;           // Samples differing from clk_flt_q
  logic                flt_last;
  logic                clk_fall;            // Filtered falling edge, one cycle

  ps2_pkg::rx_state_t  state_q;
  logic [3:0]          bit_cnt_q;           // Bits after the start bit
  logic [8:0]          shreg_q;             // Parity in bit 8, LSB first
  ps2_pkg::byte_t      data_q;
  logic                perr_q;
  logic                req_q;

  // ----------------------------------------------------------
  // Synchronizer and glitch filter
  // ----------------------------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      clk_s1_q <= 1'b1;  // Idle lines float high
      clk_s2_q <= 1'b1;
      dat_s1_q <= 1'b1;
      dat_s2_q <= 1'b1;
    end else begin
      clk_s1_q <= ps2_clk_i;
      clk_s2_q <= clk_s1_q;
      dat_s1_q <= ps2_dat_i;
      dat_s2_q <= dat_s1_q;
    end
  end

  assign flt_last = (flt_cnt_q == CNT_W'(FILTER_LEN - 1));
  assign clk_fall = flt_last & clk_flt_q & ~clk_s2_q; // Filter about to drop

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      clk_flt_q <= 1'b1;
      flt_cnt_q <= '0;
    end else if (clk_s2_q == clk_flt_q) begin
      flt_cnt_q <= '0;                // Glitch or steady level, restart
    end else if (flt_last) begin
      clk_flt_q <= clk_s2_q;          // Enough equal samples, follow the line
      flt_cnt_q <= '0;
    end else begin
      flt_cnt_q <= flt_cnt_q + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Frame FSM and handshake
  // ----------------------------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state_q   <= ps2_pkg::RX_IDLE;
      bit_cnt_q <= '0;
      req_q     <= 1'b0;
    end else begin
      unique case (state_q)
        ps2_pkg::RX_IDLE: begin
          if (clk_fall && !dat_s2_q) begin  // Start bit is a 0
            state_q   <= ps2_pkg::RX_SHIFT;
            bit_cnt_q <= '0;
          end
        end
        ps2_pkg::RX_SHIFT: begin
          if (clk_fall) begin
            if (bit_cnt_q == 4'd9) begin    // Stop bit, byte complete
              state_q <= ps2_pkg::RX_HOLD;
              req_q   <= 1'b1;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        ps2_pkg::RX_HOLD: begin
          // Frames arriving here are ignored
          if (req_q && rx.ack) req_q <= 1'b0;
          else if (!req_q && !rx.ack) state_q <= ps2_pkg::RX_IDLE;
        end
        default: state_q <= ps2_pkg::RX_IDLE;
      endcase
    end
  end

  // Shift path, data bits then parity
  always_ff @(posedge wb_clk_i) begin
    if (clk_fall && state_q == ps2_pkg::RX_SHIFT) begin
      if (bit_cnt_q == 4'd9) begin
        data_q <= shreg_q[7:0];
        perr_q <= ~^shreg_q;               // Odd parity expected
      end else begin
        shreg_q <= {dat_s2_q, shreg_q[8:1]};
      end
    end
  end

  assign rx.req  = req_q;
  assign rx.data = data_q;
  assign rx.perr = perr_q;

endmodule

// ==== design/kbc_obuf.sv ====
// ----------------------------------------------------------
// Keyboard and mouse output buffers; accept bytes from the
// receivers and hand them to the bus side, mouse first
// ----------------------------------------------------------
`timescale 1ns/1ps

module kbc_obuf (
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  ps2_rx_if.rx     kbd,      // Keyboard receiver
  ps2_rx_if.rx     mse,      // Mouse receiver
  kbc_obuf_if.obuf ob        // To the command block
);

  logic            kbd_full_q, mse_full_q;
  logic            kbd_ack_q, mse_ack_q;
  logic            perr_q;               // Sticky until a byte is popped
  ps2_pkg::byte_t  kbd_buf_q, mse_buf_q;
  logic            kbd_take, mse_take;   // Capture on this edge
  logic            kbd_pop, mse_pop;

  // Accept only into an empty buffer, otherwise receiver waits in hold
  assign kbd_take = kbd.req & ~kbd_ack_q & ~kbd_full_q;
  assign mse_take = mse.req & ~mse_ack_q & ~mse_full_q;

  // Pop clears whichever byte is being shown
  assign mse_pop = ob.pop &  mse_full_q;
  assign kbd_pop = ob.pop & ~mse_full_q;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      kbd_full_q <= 1'b0;
      mse_full_q <= 1'b0;
      kbd_ack_q  <= 1'b0;
      mse_ack_q  <= 1'b0;
      perr_q     <= 1'b0;
    end else begin
      // Handshake acceptors
      if (kbd_take) kbd_ack_q <= 1'b1;
      else if (!kbd.req) kbd_ack_q <= 1'b0; // Release after req falls
      if (mse_take) mse_ack_q <= 1'b1;
      else if (!mse.req) mse_ack_q <= 1'b0;

      // Full flags
      if (kbd_take) kbd_full_q <= 1'b1;
      else if (kbd_pop) kbd_full_q <= 1'b0;
      if (mse_take) mse_full_q <= 1'b1;
      else if (mse_pop) mse_full_q <= 1'b0;

      // A new bad byte wins over a pop in the same cycle
      if ((kbd_take && kbd.perr) || (mse_take && mse.perr)) perr_q <= 1'b1;
      else if (ob.pop) perr_q <= 1'b0;
    end
  end

  // Byte storage
  always_ff @(posedge wb_clk_i) begin
    if (kbd_take) kbd_buf_q <= kbd.data;
    if (mse_take) mse_buf_q <= mse.data;
  end

  assign kbd.ack      = kbd_ack_q;
  assign mse.ack      = mse_ack_q;
  assign ob.kbd_full  = kbd_full_q;
  assign ob.mse_full  = mse_full_q;
  assign ob.perr_flag = perr_q;
  assign ob.obuf_data = mse_full_q ? mse_buf_q : kbd_buf_q; // Mouse first

endmodule

// ==== design/kbc_cmd.sv ====
// ----------------------------------------------------------
// Wishbone side of the controller: port decode, commands,
// control and speaker registers, status and interrupts
// ----------------------------------------------------------
`timescale 1ns/1ps

module kbc_cmd (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  input  logic [15:0]     wb_dat_i,
  output logic [15:0]     wb_dat_o,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic [2:1]      wb_adr_i,
  input  logic [1:0]      wb_sel_i,
  input  logic            wb_we_i,
  output logic            wb_ack_o,
  output logic            wb_tgk_o,   // Keyboard interrupt
  output logic            wb_tgm_o,   // Mouse interrupt
  output ps2_pkg::byte_t  port61h_o,  // Chassis speaker port
  kbc_obuf_if.cmd         ob
);

  ps2_pkg::byte_t    dat_i;       // Selected byte lane
  ps2_pkg::byte_t    dat_o;
  ps2_pkg::byte_t    status;
  ps2_pkg::reg_addr_t addr;
  logic              acc, wr, rd;
  logic              dat_wr, dat_rd, cmd_wr, spk_wr;

  ps2_pkg::byte_t    cntl_q;      // Control byte
  ps2_pkg::byte_t    spk_q;       // Port 0x61
  logic              cnt_rd_q;    // Next data read returns control byte
  logic              cnt_wr_q;    // Next data write loads control byte
  logic              tst_rd_q;    // Next data read returns self-test reply
  logic              mit_rd_q;    // Next data read returns mouse-test reply
  logic              any_rd_flag;
  logic              ibf;

  // ----------------------------------------------------------
  // Bus decode
  // ----------------------------------------------------------
  assign dat_i    = wb_sel_i[0] ? wb_dat_i[7:0] : wb_dat_i[15:8];
  assign wb_dat_o = wb_sel_i[0] ? {8'h00, dat_o} : {dat_o, 8'h00};
  assign addr     = {wb_adr_i, wb_sel_i[1]};
  assign acc      = wb_cyc_i & wb_stb_i;   // No wait states
  assign wb_ack_o = acc;
  assign wr       = acc &  wb_we_i;
  assign rd       = acc & ~wb_we_i;

  assign dat_wr = wr && (addr == ps2_pkg::ADDR_DATA);
  assign dat_rd = rd && (addr == ps2_pkg::ADDR_DATA);
  assign cmd_wr = wr && (addr == ps2_pkg::ADDR_CMD);
  assign spk_wr = wr && (addr == ps2_pkg::ADDR_SPK);

  assign any_rd_flag = cnt_rd_q | tst_rd_q | mit_rd_q;
  assign ob.pop      = dat_rd & ~any_rd_flag;  // Device byte consumed

  // ----------------------------------------------------------
  // Command flags and registers
  // ----------------------------------------------------------
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      cntl_q   <= ps2_pkg::CNTL_RESET;
      spk_q    <= '0;
      cnt_rd_q <= 1'b0;
      cnt_wr_q <= 1'b0;
      tst_rd_q <= 1'b0;
      mit_rd_q <= 1'b0;
    end else if (cmd_wr) begin
      unique case (dat_i)
        ps2_pkg::CMD_RD_CNTL:   cnt_rd_q <= 1'b1;
        ps2_pkg::CMD_WR_CNTL:   cnt_wr_q <= 1'b1;
        ps2_pkg::CMD_SELF_TEST: tst_rd_q <= 1'b1;
        ps2_pkg::CMD_MSE_TEST:  mit_rd_q <= 1'b1;
        default: ;                           // Other commands ignored
      endcase
    end else if (dat_rd) begin
      cnt_rd_q <= 1'b0;  // Any data read ends a pending reply
      tst_rd_q <= 1'b0;
      mit_rd_q <= 1'b0;
    end else if (dat_wr) begin
      if (cnt_wr_q) begin
        cntl_q   <= dat_i;
        cnt_wr_q <= 1'b0;
      end
    end else if (spk_wr) begin
      spk_q <= dat_i;
    end
  end

  // ----------------------------------------------------------
  // Status byte and read mux
  // ----------------------------------------------------------
  assign ibf = any_rd_flag | ob.kbd_full | ob.mse_full;

  always_comb begin
    status                   = '0;
    status[ps2_pkg::ST_IBF]  = ibf;
    status[ps2_pkg::ST_SYS]  = 1'b1;
    status[ps2_pkg::ST_INH]  = 1'b1;
    status[ps2_pkg::ST_MOBF] = ob.mse_full;
    status[ps2_pkg::ST_PERR] = ob.perr_flag;
  end

  always_comb begin
    unique case (addr)
      ps2_pkg::ADDR_SPK:  dat_o = spk_q;
      ps2_pkg::ADDR_CMD:  dat_o = status;
      ps2_pkg::ADDR_DATA: begin
        if (cnt_rd_q)      dat_o = cntl_q;
        else if (tst_rd_q) dat_o = ps2_pkg::SELF_TEST_OK;
        else if (mit_rd_q) dat_o = ps2_pkg::MSE_TEST_OK;
        else               dat_o = ob.obuf_data;
      end
      default: dat_o = '0;  // Unused ports read 0
    endcase
  end

  // Interrupts follow the full flags when enabled
  assign wb_tgk_o  = ob.kbd_full & cntl_q[ps2_pkg::CNTL_KBD_INT];
  assign wb_tgm_o  = ob.mse_full & cntl_q[ps2_pkg::CNTL_MSE_INT];
  assign port61h_o = spk_q;

endmodule

// ==== design/ps2_kbc.sv ====
// ----------------------------------------------------------
// PS/2 keyboard and mouse controller top, a 16-bit Wishbone
// slave at ports 0x60, 0x61 and 0x64
// ----------------------------------------------------------
`timescale 1ns/1ps

module ps2_kbc #(
  parameter int FILTER_LEN = 4  // PS/2 clock glitch filter length
) (
  input  logic            wb_clk_i,
  input  logic            wb_rst_i,
  input  logic [15:0]     wb_dat_i,
  output logic [15:0]     wb_dat_o,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic [2:1]      wb_adr_i,
  input  logic [1:0]      wb_sel_i,
  input  logic            wb_we_i,
  output logic            wb_ack_o,
  output logic            wb_tgk_o,      // IRQ1
  output logic            wb_tgm_o,      // IRQ12
  output ps2_pkg::byte_t  port61h_o,     // Chassis speaker
  input  logic            ps2_kbd_clk_i,
  input  logic            ps2_kbd_dat_i,
  input  logic            ps2_mse_clk_i,
  input  logic            ps2_mse_dat_i
);

  ps2_rx_if   kbd_rx_if ();  // Keyboard receiver to buffer
  ps2_rx_if   mse_rx_if ();  // Mouse receiver to buffer
  kbc_obuf_if obuf_if ();    // Buffer to command block

  // ----------------------------------------------------------
  // Device receivers
  // ----------------------------------------------------------
  ps2_rx #(.FILTER_LEN(FILTER_LEN)) u_kbd_rx (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .ps2_clk_i(ps2_kbd_clk_i),
    .ps2_dat_i(ps2_kbd_dat_i),
    .rx       (kbd_rx_if.tx)
  );

  ps2_rx #(.FILTER_LEN(FILTER_LEN)) u_mse_rx (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .ps2_clk_i(ps2_mse_clk_i),
    .ps2_dat_i(ps2_mse_dat_i),
    .rx       (mse_rx_if.tx)
  );

  kbc_obuf u_obuf (
    .wb_clk_i(wb_clk_i),
    .wb_rst_i(wb_rst_i),
    .kbd     (kbd_rx_if.rx),
    .mse     (mse_rx_if.rx),
    .ob      (obuf_if.obuf)
  );

  kbc_cmd u_cmd (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_adr_i (wb_adr_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_ack_o (wb_ack_o),
    .wb_tgk_o (wb_tgk_o),
    .wb_tgm_o (wb_tgm_o),
    .port61h_o(port61h_o),
    .ob       (obuf_if.cmd)
  );

endmodule

// ==== tb/ps2_dev_model.svh ====
// ----------------------------------------------------------
// PS/2 device frame driver and Wishbone bus tasks, included
// inside the testbench module after its signal declarations
// ----------------------------------------------------------
`ifndef PS2_DEV_MODEL_SVH
`define PS2_DEV_MODEL_SVH

// Wait whole system clocks, land just after the rising edge
task automatic wait_clocks(input int n);
  repeat (n) @(posedge wb_clk_i);
  #DRV_DLY;
endtask

// Drive one PS/2 line pair, keyboard or mouse
task automatic set_lines(input bit to_mse, input logic clk, input logic dat);
  if (to_mse) begin
    ps2_mse_clk_i = clk;
    ps2_mse_dat_i = dat;
  end else begin
    ps2_kbd_clk_i = clk;
    ps2_kbd_dat_i = dat;
  end
endtask

// ----------------------------------------------------------
// One 11-bit device frame: start, 8 data LSB first, parity, stop
// ----------------------------------------------------------
task automatic send_frame(input bit to_mse, input ps2_pkg::byte_t data, input bit good_par);
  logic [10:0] bits;
  logic        par;
  par  = good_par ? ~^data : ^data;  // Odd parity when good
  bits = {1'b1, par, data, 1'b0};
  wait_clocks(1);
  for (int i = 0; i < 11; i++) begin
    set_lines(to_mse, 1'b1, bits[i]);  // Data moves while clock is high
    wait_clocks(HALF_CLKS);
    set_lines(to_mse, 1'b0, bits[i]);  // Host samples on this fall
    wait_clocks(HALF_CLKS);
  end
  set_lines(to_mse, 1'b1, 1'b1);       // Back to idle
endtask

// ----------------------------------------------------------
// Wishbone single access, port offset picks address and lane
// ----------------------------------------------------------
task automatic bus_access(input bit we, input ps2_pkg::reg_addr_t a,
                          input ps2_pkg::byte_t wdata, output ps2_pkg::byte_t rdata);
  int waits;
  waits = 0;
  @(posedge wb_clk_i);
  #DRV_DLY;
  wb_cyc_i = 1'b1;
  wb_stb_i = 1'b1;
  wb_we_i  = we;
  wb_adr_i = a[2:1];
  wb_sel_i = a[0] ? 2'b10 : 2'b01;      // Odd port on the upper lane
  wb_dat_i = a[0] ? {wdata, 8'h00} : {8'h00, wdata};
  @(negedge wb_clk_i);
  while (!wb_ack_o && waits < ACK_LIMIT) begin
    @(negedge wb_clk_i);
    waits++;
  end
  if (!wb_ack_o) begin
    $display("No bus acknowledge from the DUT at t=%0t", $time);
    errors++;
  end
  last_rd_word = wb_dat_o;
  rdata = a[0] ? wb_dat_o[15:8] : wb_dat_o[7:0];
  @(posedge wb_clk_i);                  // Access completes here
  #DRV_DLY;
  wb_cyc_i = 1'b0;
  wb_stb_i = 1'b0;
  wb_we_i  = 1'b0;
endtask

task automatic bus_write(input ps2_pkg::reg_addr_t a, input ps2_pkg::byte_t d);
  ps2_pkg::byte_t unused;
  bus_access(1'b1, a, d, unused);
endtask

task automatic bus_read(input ps2_pkg::reg_addr_t a, output ps2_pkg::byte_t d);
  bus_access(1'b0, a, 8'h00, d);
endtask

`endif

// ==== tb/tb_ps2_kbc.sv ====
// ----------------------------------------------------------
// Testbench for the PS/2 controller: bus registers, command
// replies, keyboard and mouse bytes, priority and parity
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_ps2_kbc;

  localparam int CLK_PERIOD  = 40;
  localparam int DRV_DLY     = 5;   // Inputs move this long after the rising edge
  localparam int HALF_CLKS   = 20;  // PS/2 half bit in system clocks
  localparam int POLL_LIMIT  = 32;
  localparam int ACK_LIMIT   = 4;
  localparam int NUM_FRAMES  = 4;
  localparam int FRAME_NS    = (11 * 2 * HALF_CLKS + 1) * CLK_PERIOD;
  localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_NS + 1000 * CLK_PERIOD;

  logic           wb_clk_i, wb_rst_i;
  logic [15:0]    wb_dat_i, wb_dat_o, last_rd_word;
  logic           wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [2:1]     wb_adr_i;
  logic [1:0]     wb_sel_i;
  logic           wb_tgk_o, wb_tgm_o;
  ps2_pkg::byte_t port61h_o;
  logic           ps2_kbd_clk_i, ps2_kbd_dat_i, ps2_mse_clk_i, ps2_mse_dat_i;
  int             errors, checks, tests, errs_at_start;

  ps2_kbc #(.FILTER_LEN(4)) UUT (.*);

  `include "ps2_dev_model.svh"

  // ----------------------------------------------------------
  // Clock, watchdog and bus protocol check
  // ----------------------------------------------------------
  initial begin
    wb_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the test sequence did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

  ack_follows_strobe: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o == (wb_cyc_i & wb_stb_i))
    else begin
      $display("ERR t=%0t wb_ack_o expected %0b actual %0b",
               $time, wb_cyc_i & wb_stb_i, wb_ack_o);
      errors++;
    end

  // Status byte as the controller should show it
  function automatic ps2_pkg::byte_t status_exp(input bit ibf, input bit mobf, input bit perr);
    ps2_pkg::byte_t s;
    s                   = '0;
    s[ps2_pkg::ST_IBF]  = ibf;
    s[ps2_pkg::ST_SYS]  = 1'b1;
    s[ps2_pkg::ST_INH]  = 1'b1;
    s[ps2_pkg::ST_MOBF] = mobf;
    s[ps2_pkg::ST_PERR] = perr;
    return s;
  endfunction

  task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    value_match: assert (act === exp)
      else begin
        $display("ERR t=%0t %s expected %02h actual %02h", $time, name, exp, act);
        errors++;
      end
  endtask

  task automatic check_status(input bit ibf, input bit mobf, input bit perr);
    ps2_pkg::byte_t st;
    bus_read(ps2_pkg::ADDR_CMD, st);
    check_val("status", status_exp(ibf, mobf, perr), st);
  endtask

  // Poll the status port until a bit sets, bounded
  task automatic wait_status(input int bit_pos);
    ps2_pkg::byte_t st;
    int             polls;
    polls = 0;
    st    = '0;
    while (!st[bit_pos] && polls < POLL_LIMIT) begin
      bus_read(ps2_pkg::ADDR_CMD, st);
      polls++;
    end
    if (!st[bit_pos]) begin
      $display("Status bit %0d still clear after %0d polls, no frame arrived", bit_pos, polls);
      errors++;
    end
  endtask

  // Canned reply: IBF up after the command, down after the read
  task automatic reply_test(input ps2_pkg::byte_t cmd, input ps2_pkg::byte_t reply);
    ps2_pkg::byte_t rd;
    bus_write(ps2_pkg::ADDR_CMD, cmd);
    check_status(1'b1, 1'b0, 1'b0);
    bus_read(ps2_pkg::ADDR_DATA, rd);
    check_val("wb_dat_o", reply, rd);
    check_status(1'b0, 1'b0, 1'b0);
  endtask

  task automatic start_test();
    errs_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == errs_at_start) $display("Test %s: ok", name);
    else $display("Test %s: %0d errors", name, errors - errs_at_start);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    ps2_pkg::byte_t rd, ctl_b, spk_b, kbd_b, mse_b;
    void'($urandom(53095));
    errors   = 0;
    checks   = 0;
    tests    = 0;
    wb_rst_i = 1'b1;
    wb_dat_i = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_sel_i = '0;
    ps2_kbd_clk_i = 1'b1;   // Idle PS/2 lines float high
    ps2_kbd_dat_i = 1'b1;
    ps2_mse_clk_i = 1'b1;
    ps2_mse_dat_i = 1'b1;
    wait_clocks(3);
    wb_rst_i = 1'b0;

    start_test();
    check_val("wb_ack_o", 8'h00, wb_ack_o);
    check_val("wb_tgk_o", 8'h00, wb_tgk_o);
    check_val("wb_tgm_o", 8'h00, wb_tgm_o);
    wb_cyc_i = 1'b1;        // Bus cycle without strobe
    wait_clocks(1);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b1;        // Strobe outside a bus cycle
    wait_clocks(1);
    wb_stb_i = 1'b0;
    check_status(1'b0, 1'b0, 1'b0);
    bus_write(ps2_pkg::ADDR_CMD, ps2_pkg::CMD_RD_CNTL);
    bus_read(ps2_pkg::ADDR_DATA, rd);
    check_val("control", ps2_pkg::CNTL_RESET, rd);
    end_test("reset");

    start_test();
    ctl_b = 8'($urandom);
    spk_b = 8'($urandom);
    bus_write(ps2_pkg::ADDR_CMD, ps2_pkg::CMD_WR_CNTL);
    bus_write(ps2_pkg::ADDR_DATA, ctl_b);
    bus_write(ps2_pkg::ADDR_CMD, ps2_pkg::CMD_RD_CNTL);
    bus_read(ps2_pkg::ADDR_DATA, rd);
    check_val("control", ctl_b, rd);
    bus_write(ps2_pkg::ADDR_SPK, spk_b);
    check_val("port61h_o", spk_b, port61h_o);
    bus_read(ps2_pkg::ADDR_SPK, rd);              // Upper lane, bits 15:8
    check_val("wb_dat_o[15:8]", spk_b, rd);
    check_val("wb_dat_o[7:0]", 8'h00, last_rd_word[7:0]);
    bus_write(ps2_pkg::ADDR_CMD, ps2_pkg::CMD_WR_CNTL);
    bus_write(ps2_pkg::ADDR_DATA, ps2_pkg::CNTL_RESET); // Interrupts back on
    end_test("control and speaker");

    start_test();
    reply_test(ps2_pkg::CMD_SELF_TEST, ps2_pkg::SELF_TEST_OK);
    reply_test(ps2_pkg::CMD_MSE_TEST, ps2_pkg::MSE_TEST_OK);
    end_test("test replies");

    start_test();
    kbd_b = 8'($urandom);
    send_frame(1'b0, kbd_b, 1'b1);
    wait_status(ps2_pkg::ST_IBF);
    check_status(1'b1, 1'b0, 1'b0);
    check_val("wb_tgk_o", 8'h01, wb_tgk_o);
    bus_read(ps2_pkg::ADDR_DATA, rd);
    check_val("wb_dat_o", kbd_b, rd);
    check_status(1'b0, 1'b0, 1'b0);
    check_val("wb_tgk_o", 8'h00, wb_tgk_o);
    end_test("keyboard byte");

    start_test();
    kbd_b = 8'($urandom);
    mse_b = 8'($urandom);
    send_frame(1'b0, kbd_b, 1'b1);
    wait_status(ps2_pkg::ST_IBF);
    send_frame(1'b1, mse_b, 1'b1);
    wait_status(ps2_pkg::ST_MOBF);
    check_status(1'b1, 1'b1, 1'b0);
    check_val("wb_tgm_o", 8'h01, wb_tgm_o);
    bus_read(ps2_pkg::ADDR_DATA, rd);             // Mouse byte comes first
    check_val("wb_dat_o", mse_b, rd);
    check_val("wb_tgm_o", 8'h00, wb_tgm_o);
    bus_read(ps2_pkg::ADDR_DATA, rd);
    check_val("wb_dat_o", kbd_b, rd);
    check_status(1'b0, 1'b0, 1'b0);
    kbd_b = 8'($urandom);
    send_frame(1'b0, kbd_b, 1'b0);               // Even parity on purpose
    wait_status(ps2_pkg::ST_IBF);
    check_status(1'b1, 1'b0, 1'b1);
    bus_read(ps2_pkg::ADDR_DATA, rd);
    check_val("wb_dat_o", kbd_b, rd);
    check_status(1'b0, 1'b0, 1'b0);
    end_test("mouse priority and parity");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+tb
design/ps2_pkg.sv
design/ps2_rx_if.sv
design/kbc_obuf_if.sv
design/ps2_rx.sv
design/kbc_obuf.sv
design/kbc_cmd.sv
design/ps2_kbc.sv
tb/tb_ps2_kbc.sv

// ==== Bender.yml ====
package:
  name: ps2_kbc

sources:
  - files:
      - design/ps2_pkg.sv
      - design/ps2_rx_if.sv
      - design/kbc_obuf_if.sv
      - design/ps2_rx.sv
      - design/kbc_obuf.sv
      - design/kbc_cmd.sv
      - design/ps2_kbc.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_ps2_kbc.sv
